/* verilog/exu_pkg.sv */
package exu_pkg;

  // data path and register id widths
  localparam int CPU_WIDTH = 64;
  localparam int REG_ADDRW = 5;

  // execute operation, ADD sits at zero so a cleared slot reads as a harmless add
  typedef enum logic [5:0] {
    ADD    = 6'd0,
    SUB    = 6'd1,
    ADDW   = 6'd2,
    SUBW   = 6'd3,
    AND    = 6'd4,
    OR     = 6'd5,
    XOR    = 6'd6,
    SLL    = 6'd7,
    SRL    = 6'd8,
    SRA    = 6'd9,
    SLLW   = 6'd10,
    SRLW   = 6'd11,
    SRAW   = 6'd12,
    SLT    = 6'd13,
    SLTU   = 6'd14,
    // multiply group
    MUL    = 6'd16,
    MULH   = 6'd17,
    MULHSU = 6'd18,
    MULHU  = 6'd19,
    MULW   = 6'd20,
    // divide and remainder group
    DIV    = 6'd24,
    DIVU   = 6'd25,
    DIVW   = 6'd26,
    DIVUW  = 6'd27,
    REM    = 6'd28,
    REMU   = 6'd29,
    REMW   = 6'd30,
    REMUW  = 6'd31,
    NONE   = 6'd63
  } exu_op_e;

  // operand sources, first name is src1 and second is src2
  typedef enum logic [1:0] {
    REG = 2'd0,
    IMM = 2'd1,
    PC4 = 2'd2,
    PCI = 2'd3
  } exu_sel_e;

  // csr read-modify-write kind
  typedef enum logic [1:0] {
    CSR_NOP = 2'd0,
    CSR_RW  = 2'd1,
    CSR_RS  = 2'd2,
    CSR_RC  = 2'd3
  } csr_op_e;

  // csr source operand, rs1 or zero-extended uimm
  typedef enum logic {
    CSR_SEL_REG = 1'b0,
    CSR_SEL_IMM = 1'b1
  } csr_src_e;

endpackage

/* verilog/div_if.sv */
`timescale 1ns/10ps
interface div_if #(
  parameter int WIDTH = 64
);

  // start is a single pulse, end_valid holds until end_ready
  logic             start;
  logic             busy;
  logic             end_valid;
  logic             end_ready;
  logic             divw;
  logic             is_signed;
  logic [WIDTH-1:0] dividend;
  logic [WIDTH-1:0] divisor;
  logic [WIDTH-1:0] quotient;
  logic [WIDTH-1:0] remainder;

  modport unit (
    output start, end_ready, divw, is_signed, dividend, divisor,
    input  busy, end_valid, quotient, remainder
  );

  modport divider (
    input  start, end_ready, divw, is_signed, dividend, divisor,
    output busy, end_valid, quotient, remainder
  );

endinterface

/* verilog/mult.sv */
`timescale 1ns/10ps
module mult #(
  parameter int WIDTH = 64
) (
  input  logic             i_mulw,
  input  logic             i_x_sign,
  input  logic             i_y_sign,
  input  logic [WIDTH-1:0] i_x,
  input  logic [WIDTH-1:0] i_y,
  output logic [WIDTH-1:0] o_hi_res,
  output logic [WIDTH-1:0] o_lw_res
);

  localparam int HALF = WIDTH / 2;

  logic signed [WIDTH:0]       x_ext;
  logic signed [WIDTH:0]       y_ext;
  logic signed [2*WIDTH+1:0]   prod;

  // one extra top bit lets a single signed multiply cover all sign mixes
  assign x_ext = {i_x_sign & i_x[WIDTH-1], i_x};
  assign y_ext = {i_y_sign & i_y[WIDTH-1], i_y};

  assign prod = x_ext * y_ext;

  assign o_hi_res = prod[2*WIDTH-1:WIDTH];

  // low half of the product only depends on the low operand bits, so mulw reuses it
  assign o_lw_res = i_mulw ? {{HALF{prod[HALF-1]}}, prod[HALF-1:0]}
                           : prod[WIDTH-1:0];

endmodule

/* verilog/div.sv */
`timescale 1ns/10ps
module div #(
  parameter int WIDTH = 64
) (
  input  logic   i_clk,
  input  logic   i_rst,
  input  logic   i_flush,
  div_if.divider div_bus
);

  localparam int HALF = WIDTH / 2;
  localparam int CNTW = $clog2(WIDTH) + 1;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RUN  = 2'd1;
  localparam logic [1:0] S_DONE = 2'd2;

  logic [1:0]       state;
  logic [CNTW-1:0]  cnt;
  logic             divw_r;
  logic             neg_q;
  logic             neg_r;
  logic [WIDTH-1:0] dsr;
  logic [WIDTH-1:0] quo;
  logic [WIDTH-1:0] rem;
  logic [WIDTH:0]   trial;
  logic [WIDTH:0]   diff;
  logic             a_neg;
  logic             b_neg;
  logic [WIDTH-1:0] a_ext;
  logic [WIDTH-1:0] b_ext;
  logic [WIDTH-1:0] a_abs;
  logic [WIDTH-1:0] b_abs;
  logic [WIDTH-1:0] q_sgn;
  logic [WIDTH-1:0] r_sgn;
  logic [WIDTH-1:0] q_out;
  logic [WIDTH-1:0] r_out;

  // word operands are taken from bit 31 down, sign or zero extended
  always_comb begin
    if (div_bus.divw) begin
      a_ext = {{HALF{div_bus.is_signed & div_bus.dividend[HALF-1]}},
               div_bus.dividend[HALF-1:0]};
      b_ext = {{HALF{div_bus.is_signed & div_bus.divisor[HALF-1]}},
               div_bus.divisor[HALF-1:0]};
    end else begin
      a_ext = div_bus.dividend;
      b_ext = div_bus.divisor;
    end
    a_neg = div_bus.is_signed & a_ext[WIDTH-1];
    b_neg = div_bus.is_signed & b_ext[WIDTH-1];
    a_abs = a_neg ? -a_ext : a_ext;
    b_abs = b_neg ? -b_ext : b_ext;
  end

  // one restoring step, diff[WIDTH] set means the trial was below the divisor
  assign trial = {rem, quo[WIDTH-1]};
  assign diff  = trial - {1'b0, dsr};

  // most negative / -1 wraps back to the dividend through abs and negate
  assign q_sgn = neg_q ? -quo : quo;
  assign r_sgn = neg_r ? -rem : rem;

  always_ff @(posedge i_clk) begin
    if (i_rst | i_flush) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: if (div_bus.start) state <= S_RUN;
        S_RUN:  if (cnt == '0) state <= S_DONE;
        S_DONE: if (div_bus.end_ready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == S_IDLE && div_bus.start) begin
      divw_r <= div_bus.divw;
      // x/0 keeps an all-ones quotient whatever the dividend sign
      neg_q  <= (a_neg ^ b_neg) & (b_ext != '0);
      neg_r  <= a_neg;
      dsr    <= b_abs;
      rem    <= '0;
      quo    <= div_bus.divw ? {a_abs[HALF-1:0], {HALF{1'b0}}} : a_abs;
      cnt    <= div_bus.divw ? CNTW'(HALF) : CNTW'(WIDTH);
    end else if (state == S_RUN) begin
      if (cnt != '0) begin
        rem <= diff[WIDTH] ? trial[WIDTH-1:0] : diff[WIDTH-1:0];
        quo <= {quo[WIDTH-2:0], ~diff[WIDTH]};
        cnt <= cnt - 1'b1;
      end else begin
        // sign fix cycle
        q_out <= divw_r ? {{HALF{q_sgn[HALF-1]}}, q_sgn[HALF-1:0]} : q_sgn;
        r_out <= divw_r ? {{HALF{r_sgn[HALF-1]}}, r_sgn[HALF-1:0]} : r_sgn;
      end
    end
  end

  assign div_bus.busy      = (state != S_IDLE);
  assign div_bus.end_valid = (state == S_DONE);
  assign div_bus.quotient  = q_out;
  assign div_bus.remainder = r_out;

endmodule

/* verilog/exu.sv */
`timescale 1ns/10ps
module exu (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_flush,
  input  logic                          i_pre_nop,
  input  logic                          i_pre_valid,
  output logic                          o_pre_ready,
  output logic                          o_post_valid,
  input  logic                          i_post_ready,
  input  logic                          i_idu_sysins,
  input  logic [exu_pkg::CPU_WIDTH-1:0] i_idu_imm,
  input  logic [exu_pkg::CPU_WIDTH-1:0] i_idu_csrs,
  input  logic [exu_pkg::CPU_WIDTH-1:0] i_idu_rs1,
  input  logic [exu_pkg::CPU_WIDTH-1:0] i_idu_rs2,
  input  exu_pkg::exu_sel_e             i_idu_exsrc,
  input  exu_pkg::exu_op_e              i_idu_exopt,
  input  exu_pkg::csr_src_e             i_idu_excsrsrc,
  input  exu_pkg::csr_op_e              i_idu_excsropt,
  input  logic [exu_pkg::REG_ADDRW-1:0] i_idu_rdid,
  input  logic                          i_idu_rdwen,
  input  logic                          i_idu_csrdwen,
  input  logic [exu_pkg::CPU_WIDTH-1:0] i_idu_pc,
  input  logic                          i_idu_nop,
  output logic [exu_pkg::CPU_WIDTH-1:0] o_exu_rs2,
  output logic [exu_pkg::REG_ADDRW-1:0] o_exu_rdid,
  output logic                          o_exu_rdwen,
  output logic [exu_pkg::CPU_WIDTH-1:0] o_exu_res,
  output logic                          o_exu_csrdwen,
  output logic [exu_pkg::CPU_WIDTH-1:0] o_exu_csrd,
  output logic [exu_pkg::CPU_WIDTH-1:0] o_exu_pc,
  output logic                          o_exu_nop
);

  import exu_pkg::*;

  logic                  pre_valid_r;
  logic                  pre_sh;
  logic                  alu_int;
  logic                  alu_mul;
  logic                  alu_div;

  logic                  idu_sysins_r;
  logic [CPU_WIDTH-1:0]  idu_imm_r;
  logic [CPU_WIDTH-1:0]  idu_csrs_r;
  logic [CPU_WIDTH-1:0]  idu_rs1_r;
  logic [CPU_WIDTH-1:0]  idu_rs2_r;
  exu_sel_e              idu_exsrc_r;
  exu_op_e               idu_exopt_r;
  csr_src_e              idu_excsrsrc_r;
  csr_op_e               idu_excsropt_r;
  logic [REG_ADDRW-1:0]  idu_rdid_r;
  logic                  idu_rdwen_r;
  logic                  idu_csrdwen_r;
  logic [CPU_WIDTH-1:0]  idu_pc_r;
  logic                  idu_nop_r;

  logic [CPU_WIDTH-1:0]  src1;
  logic [CPU_WIDTH-1:0]  src2;
  logic [CPU_WIDTH-1:0]  int_res;
  logic [CPU_WIDTH-1:0]  mul_res;
  logic [CPU_WIDTH-1:0]  div_res;
  logic [CPU_WIDTH-1:0]  sys_src;
  logic [CPU_WIDTH-1:0]  sys_rdres;

  logic                  mulw;
  logic                  mul_x_sign;
  logic                  mul_y_sign;
  logic [CPU_WIDTH-1:0]  mul_src1;
  logic [CPU_WIDTH-1:0]  mul_src2;
  logic [CPU_WIDTH-1:0]  mul_hires;
  logic [CPU_WIDTH-1:0]  mul_lwres;
  logic                  divw;
  logic                  div_signed;

  div_if #(.WIDTH(CPU_WIDTH)) div_bus ();

  function automatic logic [CPU_WIDTH-1:0] sext_w(input logic [31:0] w);
    return {{(CPU_WIDTH-32){w[31]}}, w};
  endfunction

  // held slot frees up when empty or when its result leaves this cycle
  assign o_pre_ready  = (o_post_valid & i_post_ready) | ~pre_valid_r;
  assign pre_sh       = i_pre_valid & o_pre_ready;
  // a divide only reports once the divider holds its result
  assign o_post_valid = pre_valid_r & (alu_div ? div_bus.end_valid : 1'b1);

  always_ff @(posedge i_clk) begin
    if (i_rst | i_flush) begin
      pre_valid_r <= 1'b0;
    end else if (o_pre_ready) begin
      pre_valid_r <= i_pre_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_flush | pre_sh) begin
      if (i_flush | i_pre_nop) begin
        idu_sysins_r   <= 1'b0;
        idu_imm_r      <= '0;
        idu_csrs_r     <= '0;
        idu_rs1_r      <= '0;
        idu_rs2_r      <= '0;
        idu_exsrc_r    <= REG;
        idu_exopt_r    <= ADD;
        idu_excsrsrc_r <= CSR_SEL_REG;
        idu_excsropt_r <= CSR_NOP;
        idu_rdid_r     <= '0;
        idu_rdwen_r    <= 1'b0;
        idu_csrdwen_r  <= 1'b0;
        idu_pc_r       <= '0;
      end else begin
        idu_sysins_r   <= i_idu_sysins;
        idu_imm_r      <= i_idu_imm;
        idu_csrs_r     <= i_idu_csrs;
        idu_rs1_r      <= i_idu_rs1;
        idu_rs2_r      <= i_idu_rs2;
        idu_exsrc_r    <= i_idu_exsrc;
        idu_exopt_r    <= i_idu_exopt;
        idu_excsrsrc_r <= i_idu_excsrsrc;
        idu_excsropt_r <= i_idu_excsropt;
        idu_rdid_r     <= i_idu_rdid;
        idu_rdwen_r    <= i_idu_rdwen;
        idu_csrdwen_r  <= i_idu_csrdwen;
        idu_pc_r       <= i_idu_pc;
      end
      idu_nop_r <= ~i_flush & (i_pre_nop | i_idu_nop);
    end
  end

  // csr: rd gets the old value, csrd the updated one
  assign sys_src   = (idu_excsrsrc_r == CSR_SEL_IMM) ? idu_imm_r : idu_rs1_r;
  assign sys_rdres = (idu_excsropt_r == CSR_NOP) ? '0 : idu_csrs_r;

  always_comb begin
    case (idu_excsropt_r)
      CSR_RW:  o_exu_csrd = sys_src;
      CSR_RS:  o_exu_csrd = idu_csrs_r | sys_src;
      CSR_RC:  o_exu_csrd = idu_csrs_r & ~sys_src;
      default: o_exu_csrd = '0;
    endcase
  end

  // operand select
  assign src1 = (idu_exsrc_r == PC4 || idu_exsrc_r == PCI) ? idu_pc_r : idu_rs1_r;

  always_comb begin
    case (idu_exsrc_r)
      REG:     src2 = idu_rs2_r;
      PC4:     src2 = CPU_WIDTH'(4);
      default: src2 = idu_imm_r;
    endcase
  end

  always_comb begin
    alu_int = 1'b1;
    case (idu_exopt_r)
      ADD:     int_res = src1 + src2;
      SUB:     int_res = src1 - src2;
      ADDW:    int_res = sext_w(src1[31:0] + src2[31:0]);
      SUBW:    int_res = sext_w(src1[31:0] - src2[31:0]);
      AND:     int_res = src1 & src2;
      OR:      int_res = src1 | src2;
      XOR:     int_res = src1 ^ src2;
      SLL:     int_res = src1 << src2[5:0];
      SRL:     int_res = src1 >> src2[5:0];
      SRA:     int_res = $signed(src1) >>> src2[5:0];
      SLLW:    int_res = sext_w(src1[31:0] << src2[4:0]);
      SRLW:    int_res = sext_w(src1[31:0] >> src2[4:0]);
      SRAW:    int_res = sext_w(32'($signed(src1[31:0]) >>> src2[4:0]));
      SLT:     int_res = CPU_WIDTH'($signed(src1) < $signed(src2));
      SLTU:    int_res = CPU_WIDTH'(src1 < src2);
      default: begin
        int_res = '0;
        alu_int = 1'b0;
      end
    endcase
  end

  // multiplier, operands held at zero when idle
  always_comb begin
    alu_mul    = 1'b1;
    mulw       = 1'b0;
    mul_x_sign = 1'b1;
    mul_y_sign = 1'b1;
    mul_res    = mul_hires;
    case (idu_exopt_r)
      MUL:     mul_res = mul_lwres;
      MULH:    ;
      MULHSU:  mul_y_sign = 1'b0;
      MULHU: begin
        mul_x_sign = 1'b0;
        mul_y_sign = 1'b0;
      end
      MULW: begin
        mulw    = 1'b1;
        mul_res = mul_lwres;
      end
      default: begin
        alu_mul    = 1'b0;
        mul_x_sign = 1'b0;
        mul_y_sign = 1'b0;
        mul_res    = '0;
      end
    endcase
  end

  assign mul_src1 = alu_mul ? src1 : '0;
  assign mul_src2 = alu_mul ? src2 : '0;

  mult #(.WIDTH(CPU_WIDTH)) u_mult (
    .i_mulw   (mulw),
    .i_x_sign (mul_x_sign),
    .i_y_sign (mul_y_sign),
    .i_x      (mul_src1),
    .i_y      (mul_src2),
    .o_hi_res (mul_hires),
    .o_lw_res (mul_lwres)
  );

  // divider decode
  always_comb begin
    alu_div    = 1'b1;
    divw       = 1'b0;
    div_signed = 1'b0;
    div_res    = div_bus.quotient;
    case (idu_exopt_r)
      DIV:     div_signed = 1'b1;
      DIVU:    ;
      DIVW: begin
        divw       = 1'b1;
        div_signed = 1'b1;
      end
      DIVUW:   divw = 1'b1;
      REM: begin
        div_signed = 1'b1;
        div_res    = div_bus.remainder;
      end
      REMU:    div_res = div_bus.remainder;
      REMW: begin
        divw       = 1'b1;
        div_signed = 1'b1;
        div_res    = div_bus.remainder;
      end
      REMUW: begin
        divw    = 1'b1;
        div_res = div_bus.remainder;
      end
      default: begin
        alu_div = 1'b0;
        div_res = '0;
      end
    endcase
  end

  assign div_bus.start     = alu_div & pre_valid_r & ~div_bus.busy;
  assign div_bus.end_ready = alu_div & pre_valid_r & i_post_ready;
  assign div_bus.divw      = divw;
  assign div_bus.is_signed = div_signed;
  assign div_bus.dividend  = alu_div ? src1 : '0;
  assign div_bus.divisor   = alu_div ? src2 : '0;

  div #(.WIDTH(CPU_WIDTH)) u_div (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_flush (i_flush),
    .div_bus (div_bus)
  );

  // result select, csr read wins over the alu
  assign o_exu_res = idu_sysins_r ? sys_rdres :
                     alu_div      ? div_res   :
                     alu_mul      ? mul_res   :
                     alu_int      ? int_res   : '0;

  assign o_exu_rs2     = idu_rs2_r;
  assign o_exu_rdid    = idu_rdid_r;
  assign o_exu_rdwen   = idu_rdwen_r;
  assign o_exu_csrdwen = idu_csrdwen_r;
  assign o_exu_pc      = idu_pc_r;
  assign o_exu_nop     = idu_nop_r;

endmodule

/* testbench/exu_tb.sv */
`timescale 1ns/10ps
module exu_tb;

  import exu_pkg::*;

  typedef struct packed {
    exu_op_e              op;
    exu_sel_e             sel;
    csr_op_e              cop;
    csr_src_e             csrc;
    logic                 sys;
    logic                 nop;
    logic                 flush;
    logic [CPU_WIDTH-1:0] rs1;
    logic [CPU_WIDTH-1:0] rs2;
    logic [CPU_WIDTH-1:0] imm;
    logic [CPU_WIDTH-1:0] pc;
    logic [CPU_WIDTH-1:0] csrs;
    logic [CPU_WIDTH-1:0] exp_res;
    logic [CPU_WIDTH-1:0] exp_csrd;
  } test_t;

  logic                 i_clk;
  logic                 i_rst;
  logic                 i_flush;
  logic                 i_pre_nop;
  logic                 i_pre_valid;
  logic                 o_pre_ready;
  logic                 o_post_valid;
  logic                 i_post_ready;
  logic                 i_idu_sysins;
  logic [CPU_WIDTH-1:0] i_idu_imm;
  logic [CPU_WIDTH-1:0] i_idu_csrs;
  logic [CPU_WIDTH-1:0] i_idu_rs1;
  logic [CPU_WIDTH-1:0] i_idu_rs2;
  exu_sel_e             i_idu_exsrc;
  exu_op_e              i_idu_exopt;
  csr_src_e             i_idu_excsrsrc;
  csr_op_e              i_idu_excsropt;
  logic [REG_ADDRW-1:0] i_idu_rdid;
  logic                 i_idu_rdwen;
  logic                 i_idu_csrdwen;
  logic [CPU_WIDTH-1:0] i_idu_pc;
  logic                 i_idu_nop;
  logic [CPU_WIDTH-1:0] o_exu_rs2;
  logic [REG_ADDRW-1:0] o_exu_rdid;
  logic                 o_exu_rdwen;
  logic [CPU_WIDTH-1:0] o_exu_res;
  logic                 o_exu_csrdwen;
  logic [CPU_WIDTH-1:0] o_exu_csrd;
  logic [CPU_WIDTH-1:0] o_exu_pc;
  logic                 o_exu_nop;

  test_t tests[$];
  string names[$];
  int    errors;
  int    passed;
  int    cycles;
  int    limit;
  bit    bad;
  bit    hold_ready;

  exu dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // random back-pressure, or forced low while a flush is staged
  always @(posedge i_clk) begin
    #1;
    i_post_ready = hold_ready ? 1'b0 : ($urandom % 3 != 0);
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("run timed out waiting for o_post_valid after %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
      bad = 1'b1;
    end
  endtask

  task automatic add(input string n, input exu_op_e op, input exu_sel_e sel,
                     input logic [63:0] a, input logic [63:0] b, input logic [63:0] imm,
                     input logic [63:0] pc, input logic [63:0] exp, input logic [1:0] flags);
    test_t t;
    t = '{op: op, sel: sel, cop: CSR_NOP, csrc: CSR_SEL_REG, sys: 1'b0, nop: flags[1],
          flush: flags[0], rs1: a, rs2: b, imm: imm, pc: pc, csrs: '0, exp_res: exp,
          exp_csrd: '0};
    tests.push_back(t);
    names.push_back(n);
  endtask

  task automatic add_csr(input string n, input csr_op_e cop, input csr_src_e csrc,
                         input logic [63:0] csrs, input logic [63:0] a, input logic [63:0] imm,
                         input logic [63:0] exp_res, input logic [63:0] exp_csrd);
    test_t t;
    t = '{op: NONE, sel: REG, cop: cop, csrc: csrc, sys: 1'b1, nop: 1'b0, flush: 1'b0,
          rs1: a, rs2: 64'h77, imm: imm, pc: 64'h300, csrs: csrs, exp_res: exp_res,
          exp_csrd: exp_csrd};
    tests.push_back(t);
    names.push_back(n);
  endtask

  task automatic fill_table();
    add("add", ADD, REG, 5, 7, 0, 64'h100, 12, 2'b00);
    add("sub", SUB, REG, 5, 7, 0, 64'h104, 64'hFFFF_FFFF_FFFF_FFFE, 2'b00);
    add("addi", ADD, IMM, 100, 3, '1, 64'h108, 99, 2'b00);
    add("pc4", ADD, PC4, 9, 9, 9, 64'h8000_0000, 64'h8000_0004, 2'b00);
    add("auipc", ADD, PCI, 9, 9, 64'h2000, 64'h1000, 64'h3000, 2'b00);
    add("and", AND, REG, 64'hF0F0, 64'hFF00, 0, 64'h10c, 64'hF000, 2'b00);
    add("or", OR, REG, 64'hF0F0, 64'hFF00, 0, 64'h110, 64'hFFF0, 2'b00);
    add("xor", XOR, REG, 64'hF0F0, 64'hFF00, 0, 64'h114, 64'h0FF0, 2'b00);
    add("sll_63", SLL, REG, 1, 63, 0, 64'h118, 64'h8000_0000_0000_0000, 2'b00);
    add("sll_wrap", SLL, REG, 1, 68, 0, 64'h11c, 16, 2'b00);
    add("srl", SRL, REG, 64'h8000_0000_0000_0000, 4, 0, 64'h120, 64'h0800_0000_0000_0000, 2'b00);
    add("sra", SRA, REG, 64'h8000_0000_0000_0000, 4, 0, 64'h124, 64'hF800_0000_0000_0000, 2'b00);
    add("addw", ADDW, REG, 64'h7FFF_FFFF, 1, 0, 64'h128, 64'hFFFF_FFFF_8000_0000, 2'b00);
    add("subw", SUBW, REG, 0, 1, 0, 64'h12c, '1, 2'b00);
    add("sllw", SLLW, REG, 1, 31, 0, 64'h130, 64'hFFFF_FFFF_8000_0000, 2'b00);
    add("srlw", SRLW, REG, 64'hFFFF_FFFF_8000_0000, 4, 0, 64'h134, 64'h0800_0000, 2'b00);
    add("sraw", SRAW, REG, 64'hFFFF_FFFF_8000_0000, 4, 0, 64'h138, 64'hFFFF_FFFF_F800_0000, 2'b00);
    add("slt", SLT, REG, '1, 1, 0, 64'h13c, 1, 2'b00);
    add("sltu", SLTU, REG, '1, 1, 0, 64'h140, 0, 2'b00);
    add("slti", SLT, IMM, 5, 9, '1, 64'h144, 0, 2'b00);
    add("mul", MUL, REG, 64'hFFFF_FFFF_FFFF_FFFD, 5, 0, 64'h148, 64'hFFFF_FFFF_FFFF_FFF1, 2'b00);
    add("mulh", MULH, REG, 64'hFFFF_FFFF_FFFF_FFFD, 5, 0, 64'h14c, '1, 2'b00);
    add("mulh_big", MULH, REG, 64'h4000_0000_0000_0000, 4, 0, 64'h150, 1, 2'b00);
    add("mulhu", MULHU, REG, '1, '1, 0, 64'h154, 64'hFFFF_FFFF_FFFF_FFFE, 2'b00);
    add("mulhsu", MULHSU, REG, '1, '1, 0, 64'h158, '1, 2'b00);
    add("mulw", MULW, REG, 64'h1_0000, 64'h8000, 0, 64'h15c, 64'hFFFF_FFFF_8000_0000, 2'b00);
    add("div", DIV, REG, -64'sd20, 6, 0, 64'h160, 64'hFFFF_FFFF_FFFF_FFFD, 2'b00);
    add("rem", REM, REG, -64'sd20, 6, 0, 64'h164, 64'hFFFF_FFFF_FFFF_FFFE, 2'b00);
    add("divu", DIVU, REG, 100, 7, 0, 64'h168, 14, 2'b00);
    add("remu", REMU, REG, 100, 7, 0, 64'h16c, 2, 2'b00);
    add("div_zero", DIV, REG, 123, 0, 0, 64'h170, '1, 2'b00);
    add("rem_zero", REM, REG, 123, 0, 0, 64'h174, 123, 2'b00);
    add("div_ovf", DIV, REG, 64'h8000_0000_0000_0000, '1, 0, 64'h178,
        64'h8000_0000_0000_0000, 2'b00);
    add("rem_ovf", REM, REG, 64'h8000_0000_0000_0000, '1, 0, 64'h17c, 0, 2'b00);
    add("divw", DIVW, REG, 64'hFFFF_FFF0, 3, 0, 64'h180, 64'hFFFF_FFFF_FFFF_FFFB, 2'b00);
    add("divw_ovf", DIVW, REG, 64'h8000_0000, 64'hFFFF_FFFF, 0, 64'h184,
        64'hFFFF_FFFF_8000_0000, 2'b00);
    add("divuw", DIVUW, REG, 64'hFFFF_FFFF_FFFF_FFF0, 2, 0, 64'h188, 64'h7FFF_FFF8, 2'b00);
    add("remw", REMW, REG, -64'sd7, 2, 0, 64'h18c, '1, 2'b00);
    add("remuw_zero", REMUW, REG, 64'hFFFF_FFFF, 0, 0, 64'h190, '1, 2'b00);
    add_csr("csrrw", CSR_RW, CSR_SEL_REG, 64'h1234, 64'hFF, 0, 64'h1234, 64'hFF);
    add_csr("csrrwi", CSR_RW, CSR_SEL_IMM, 64'h55, 64'hFF, 7, 64'h55, 64'h7);
    add_csr("csrrsi", CSR_RS, CSR_SEL_IMM, 64'h10, 64'hFF, 5, 64'h10, 64'h15);
    add_csr("csrrs", CSR_RS, CSR_SEL_REG, 64'h10, 64'h3, 0, 64'h10, 64'h13);
    add_csr("csrrc", CSR_RC, CSR_SEL_REG, 64'hFF, 64'h0F, 0, 64'hFF, 64'hF0);
    add_csr("csrrci", CSR_RC, CSR_SEL_IMM, 64'h3, 64'hFF, 1, 64'h3, 64'h2);
    add("flush_add", ADD, REG, 1, 2, 0, 64'h200, 3, 2'b01);
    add("after_flush", ADD, REG, 3, 4, 0, 64'h204, 7, 2'b00);
    add("flush_div", DIV, REG, 1000, 3, 0, 64'h208, 333, 2'b01);
    add("div_after", DIV, REG, 1000, 7, 0, 64'h20c, 142, 2'b00);
    add("pre_nop", SUB, REG, 5, 9, 0, 64'h210, 0, 2'b10);
  endtask

  task automatic run_test(input int i);
    test_t                t;
    bit                   held;
    bit                   done;
    logic [CPU_WIDTH-1:0] snap_res;
    logic [CPU_WIDTH-1:0] snap_csrd;
    logic [CPU_WIDTH-1:0] snap_pc;
    t = tests[i];
    bad = 1'b0;
    @(negedge i_clk);
    hold_ready = t.flush;
    @(posedge i_clk);
    #1;
    i_idu_exopt    = t.op;
    i_idu_exsrc    = t.sel;
    i_idu_excsropt = t.cop;
    i_idu_excsrsrc = t.csrc;
    i_idu_sysins   = t.sys;
    i_idu_csrdwen  = t.sys;
    i_idu_rs1      = t.rs1;
    i_idu_rs2      = t.rs2;
    i_idu_imm      = t.imm;
    i_idu_pc       = t.pc;
    i_idu_csrs     = t.csrs;
    i_idu_rdid     = i[REG_ADDRW-1:0];
    i_pre_nop      = t.nop;
    i_pre_valid    = 1'b1;
    do @(negedge i_clk); while (!o_pre_ready);
    @(posedge i_clk);
    #1;
    i_pre_valid = 1'b0;
    i_pre_nop   = 1'b0;
    if (t.flush) begin
      // divides are caught mid-iteration
      repeat ((t.op >= DIV && t.op <= REMUW) ? 10 : 2) @(posedge i_clk);
      #1 i_flush = 1'b1;
      @(posedge i_clk);
      #1 i_flush = 1'b0;
      repeat (3) begin
        @(negedge i_clk);
        if (o_post_valid) begin
          $display("flushed instruction %s still presents a result", names[i]);
          errors++;
          bad = 1'b1;
        end
      end
      hold_ready = 1'b0;
    end else begin
      held = 1'b0;
      done = 1'b0;
      while (!done) begin
        @(negedge i_clk);
        if (held) begin
          check({names[i], " held valid"}, 1, o_post_valid);
          check({names[i], " held res"}, snap_res, o_exu_res);
          check({names[i], " held csrd"}, snap_csrd, o_exu_csrd);
          check({names[i], " held pc"}, snap_pc, o_exu_pc);
        end
        held = 1'b0;
        if (o_post_valid && i_post_ready) begin
          check({names[i], " res"}, t.exp_res, o_exu_res);
          check({names[i], " csrd"}, t.exp_csrd, o_exu_csrd);
          check({names[i], " nop"}, t.nop, o_exu_nop);
          check({names[i], " rdid"}, t.nop ? 0 : i[REG_ADDRW-1:0], o_exu_rdid);
          check({names[i], " rdwen"}, !t.nop, o_exu_rdwen);
          check({names[i], " csrdwen"}, t.nop ? 0 : t.sys, o_exu_csrdwen);
          check({names[i], " pc"}, t.nop ? 0 : t.pc, o_exu_pc);
          check({names[i], " rs2"}, t.nop ? 0 : t.rs2, o_exu_rs2);
          done = 1'b1;
        end else if (o_post_valid) begin
          check({names[i], " pre_ready while held"}, 0, o_pre_ready);
          snap_res  = o_exu_res;
          snap_csrd = o_exu_csrd;
          snap_pc   = o_exu_pc;
          held      = 1'b1;
        end
      end
      @(posedge i_clk);
    end
    if (!bad) passed++;
    $display("%-12s %s", names[i], bad ? "FAIL" : "ok");
  endtask

  initial begin
    void'($urandom(10));
    limit          = 100000;
    errors         = 0;
    passed         = 0;
    cycles         = 0;
    hold_ready     = 1'b0;
    i_rst          = 1'b1;
    i_flush        = 1'b0;
    i_pre_nop      = 1'b0;
    i_pre_valid    = 1'b0;
    i_post_ready   = 1'b0;
    i_idu_sysins   = 1'b0;
    i_idu_imm      = '0;
    i_idu_csrs     = '0;
    i_idu_rs1      = '0;
    i_idu_rs2      = '0;
    i_idu_exsrc    = REG;
    i_idu_exopt    = ADD;
    i_idu_excsrsrc = CSR_SEL_REG;
    i_idu_excsropt = CSR_NOP;
    i_idu_rdid     = '0;
    i_idu_rdwen    = 1'b1;
    i_idu_csrdwen  = 1'b0;
    i_idu_pc       = '0;
    i_idu_nop      = 1'b0;
    fill_table();
    limit = tests.size() * 200 + 16;
    repeat (16) @(posedge i_clk);
    #1 i_rst = 1'b0;
    for (int i = 0; i < tests.size(); i++) begin
      run_test(i);
    end
    $display("%0d of %0d tests ok, %0d mismatches", passed, tests.size(), errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
verilog/exu_pkg.sv
verilog/div_if.sv
verilog/mult.sv
verilog/div.sv
verilog/exu.sv
testbench/exu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module exu_tb -f filelist.f -o exu_sim
./obj_dir/exu_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
  exit 0
else
  exit 1
fi
